/* project.f */
flash_dump_pkg.sv
spi_flash_reader.sv
byte_fifo.sv
dump_formatter.sv
uart_tx.sv
flash_dump_top.sv
spi_flash_model.sv
tb_flash_dump.sv

/* Bender.yml */
package:
  name: flash_dump

sources:
  - flash_dump_pkg.sv
  - spi_flash_reader.sv
  - byte_fifo.sv
  - dump_formatter.sv
  - uart_tx.sv
  - flash_dump_top.sv
  - target: simulation
    files:
      - spi_flash_model.sv
      - tb_flash_dump.sv

/* tb_flash_dump.sv */
// flash dump testbench
// drives start, receives the serial text lines, compares them
// with lines built from the flash contents, and checks the
// READ commands seen by the flash model

`timescale 1ns/100ps
`default_nettype none

module tb_flash_dump;

logic clk27, rst, start;
wire busy, serial_tx, flash_clk, flash_sel, flash_out, flash_in;

logic [7:0] exp_mem [256];  // copy of the flash contents
logic [7:0] rx_q [$];  // received characters
logic [7:0] rx_byte, got, want, fill;
logic [flash_dump_pkg::LINE_CHARS * 8 - 1 : 0] want_line;
event char_done;
integer seed;
int rx_bit, rx_lines, col, i;
int errors, char_errors, passed, failed, err_mark, char_mark;
longint limit_ns;

flash_dump_top DUT (
	.clk27(clk27), .rst(rst), .start(start), .busy(busy),
	.serial_tx(serial_tx),
	.flash_clk(flash_clk), .flash_sel(flash_sel),
	.flash_out(flash_out), .flash_in(flash_in)
);

spi_flash_model flash (
	.flash_clk(flash_clk), .flash_sel(flash_sel),
	.flash_out(flash_out), .flash_in(flash_in)
);

always #10 clk27 = ~clk27;

// expected text line, first character in the top byte
function automatic logic [flash_dump_pkg::LINE_CHARS * 8 - 1 : 0] ref_line(
	input logic [23:0] addr, input logic [7:0] data);
	logic [flash_dump_pkg::LINE_CHARS * 8 - 1 : 0] line;
	logic [7:0] c;
	int k;
	line = '0;
	for (k = 0; k < flash_dump_pkg::LINE_CHARS; k++) begin
		if (k < 8)
			c = addr[23 - k] ? "1" : "0";
		else if (k == 8 || k == 17)
			c = "_";
		else if (k < 17)
			c = addr[24 - k] ? "1" : "0";  // middle group
		else if (k < 26)
			c = addr[25 - k] ? "1" : "0";
		else if (k == 26 || k == 28)
			c = " ";
		else if (k == 27)
			c = data;  // raw byte
		else if (k < 37)
			c = data[36 - k] ? "1" : "0";
		else
			c = (k == 37) ? 8'h0d : 8'h0a;
		line[(flash_dump_pkg::LINE_CHARS - 1 - k) * 8 +: 8] = c;
	end
	return line;
endfunction

task automatic expect_level(input string name, input logic got_v, input logic want_v);
	assert (got_v === want_v) else begin
		$display("[FAIL] %s expected %h got %h", name, want_v, got_v);
		errors++;
	end
endtask

task automatic report_test(input int num, input string what, input logic ok);
	if (ok) begin
		passed++;
		$display("test %0d %s: pass", num, what);
	end else begin
		failed++;
		$display("test %0d %s: fail", num, what);
	end
endtask

// one dump, with optional start pulses while busy
task automatic dump_and_drain(input int extra_starts);
	int n;
	rx_lines = 0;
	col = 0;
	flash.restart();
	@(negedge clk27) start = 1'b1;
	@(negedge clk27) start = 1'b0;
	expect_level("busy", busy, 1'b1);
	for (n = 0; n < extra_starts; n++) begin
		// first pulse during the flash reads, later ones near the end of the text
		if (n == 0)
			repeat (5000) @(negedge clk27);
		else
			while (busy && rx_lines < flash_dump_pkg::DUMP_BYTES - 2)
				@(negedge clk27);
		start = 1'b1;
		@(negedge clk27) start = 1'b0;
		expect_level("busy", busy, 1'b1);
	end
	while (busy)
		@(negedge clk27);
	repeat (4) @(negedge clk27);  // compare process catches up
	assert (rx_lines == flash_dump_pkg::DUMP_BYTES && col == 0) else begin
		$display("[FAIL] lines expected %h got %h (column %0d)",
			flash_dump_pkg::DUMP_BYTES, rx_lines, col);
		errors++;
	end
endtask

// ------------------------------------------------------------------------
// serial receiver, sampled at mid-bit
// ------------------------------------------------------------------------
always begin
	@(negedge serial_tx);
	repeat (flash_dump_pkg::CLKS_PER_BIT / 2) @(negedge clk27);
	for (rx_bit = 0; rx_bit < 8; rx_bit++) begin
		repeat (flash_dump_pkg::CLKS_PER_BIT) @(negedge clk27);
		rx_byte[rx_bit] = serial_tx;  // low bit first
	end
	repeat (flash_dump_pkg::CLKS_PER_BIT) @(negedge clk27);
	assert (serial_tx === 1'b1) else begin
		$display("stop bit missing after character %h", rx_byte);
		errors++;
	end
	rx_q.push_back(rx_byte);
	-> char_done;
end

always begin
	@(char_done);
	while (rx_q.size() > 0) begin
		got = rx_q.pop_front();
		if (rx_lines >= flash_dump_pkg::DUMP_BYTES) begin
			$display("character %h arrived after the last expected line", got);
			errors++;
		end else begin
			want_line = ref_line(24'(rx_lines), exp_mem[rx_lines]);
			want = want_line[(flash_dump_pkg::LINE_CHARS - 1 - col) * 8 +: 8];
			assert (got == want) else begin
				$display("[FAIL] tx_char expected %h got %h line %0d col %0d",
					want, got, rx_lines, col);
				errors++;
				char_errors++;
			end
			col++;
			if (col == flash_dump_pkg::LINE_CHARS) begin
				col = 0;
				rx_lines++;
			end
		end
	end
end

// two dumps, 50 % margin
initial begin
	limit_ns = longint'(2) * flash_dump_pkg::DUMP_BYTES * flash_dump_pkg::LINE_CHARS
		* 10 * flash_dump_pkg::CLKS_PER_BIT * 20 * 3 / 2;
	#(limit_ns);
	$display("timeout, the dump did not finish in time");
	$display("ERRORS FOUND");
	$finish;
end

initial begin
	clk27 = 1'b0;
	rst = 1'b1;
	start = 1'b0;
	seed = 32'hc27e4a45;
	errors = 0;
	char_errors = 0;
	passed = 0;
	failed = 0;
	rx_lines = 0;
	col = 0;
	for (i = 0; i < 256; i++) begin
		fill = $random(seed);
		flash.mem[i] = fill;
		exp_mem[i] = fill;
	end
	repeat (3) @(negedge clk27);
	rst = 1'b0;

	err_mark = errors;
	@(negedge clk27);
	expect_level("serial_tx", serial_tx, 1'b1);
	expect_level("flash_sel", flash_sel, 1'b1);
	expect_level("flash_clk", flash_clk, 1'b0);
	expect_level("busy", busy, 1'b0);
	report_test(1, "idle outputs after reset", errors == err_mark);

	err_mark = errors;
	dump_and_drain(0);
	report_test(2, "single dump lines", errors == err_mark);

	err_mark = errors;
	assert (flash.cmd_count > 1) else begin
		$display("only %0d READ command seen, the reader never resumed", flash.cmd_count);
		errors++;
	end
	assert (flash.bad_cmds == 0) else begin
		$display("%0d READ commands did not continue at the next address", flash.bad_cmds);
		errors++;
	end
	report_test(3, "pause and resume commands", errors == err_mark);

	err_mark = errors;
	char_mark = char_errors;
	dump_and_drain(2);
	report_test(4, "start ignored while busy",
		errors - char_errors == err_mark - char_mark);
	err_mark = errors;
	assert (flash.bad_cmds == 0) else begin
		$display("second dump issued %0d misplaced READ commands", flash.bad_cmds);
		errors++;
	end
	report_test(5, "second dump repeats from address 0",
		errors == err_mark && char_errors == char_mark
		&& rx_lines == flash_dump_pkg::DUMP_BYTES);

	$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
	if (errors == 0 && failed == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

`default_nettype wire

/* spi_flash_model.sv */
// behavioural spi flash for simulation
// mode 0, answers READ (0x03) with bytes from a memory that the
// testbench fills, and records where each command starts

`timescale 1ns/100ps
`default_nettype none

module spi_flash_model (
	input wire flash_clk,
	input wire flash_sel,
	input wire flash_out,
	output logic flash_in
);

logic [7:0] mem [256];  // filled by the testbench
logic [flash_dump_pkg::BITS + flash_dump_pkg::ADDR_BITS - 1 : 0] cmd_shift;  // opcode & address
logic [flash_dump_pkg::ADDR_BITS - 1 : 0] base_addr;
logic [flash_dump_pkg::ADDR_BITS - 1 : 0] next_addr;  // where the next READ must begin
logic [flash_dump_pkg::ADDR_BITS - 1 : 0] cur_addr;
int bits_in = 0;  // rising edges since select fell
int data_bit;
int cmd_count = 0;
int bad_cmds = 0;

initial begin
	flash_in = 1'b0;
	next_addr = '0;
end

// new dump from address 0
task automatic restart();
	next_addr = '0;
	cmd_count = 0;
	bad_cmds = 0;
endtask

always @(negedge flash_sel)
	bits_in = 0;

always @(posedge flash_clk) begin
	if (!flash_sel) begin
		if (bits_in < 32)
			cmd_shift = {cmd_shift[30:0], flash_out};
		bits_in = bits_in + 1;
		if (bits_in == 32) begin  // command complete
			cmd_count = cmd_count + 1;
			base_addr = cmd_shift[flash_dump_pkg::ADDR_BITS - 1 : 0];
			if (cmd_shift[31:24] != flash_dump_pkg::OP_READ || base_addr != next_addr)
				bad_cmds = bad_cmds + 1;
		end
	end
end

// data bits change while the clock is low, msb first
always @(negedge flash_clk) begin
	if (!flash_sel && bits_in >= 32) begin
		data_bit = bits_in - 32;
		cur_addr = base_addr + (data_bit / 8);
		flash_in = mem[cur_addr[7:0]][7 - data_bit % 8];
	end
end

// whole bytes delivered so far decide the resume address
always @(posedge flash_sel) begin
	if (bits_in >= 32)
		next_addr = base_addr + (bits_in - 32) / 8;
end

endmodule

`default_nettype wire

/* flash_dump_top.sv */
// flash dump top level
// spi reader -> fifo -> line formatter -> uart.
// busy covers one dump from start until the last character is sent

`timescale 1ns/100ps
`default_nettype none

module flash_dump_top (
	input wire clk27,
	input wire rst,
	input wire start,
	output logic busy,

	output logic serial_tx,

	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out,
	input wire flash_in
);

logic go;  // start while not busy
logic wr_valid, wr_ready, rd_valid, rd_ready, tx_valid, tx_ready;
logic [flash_dump_pkg::ADDR_BITS - 1 : 0] wr_addr, rd_addr;
logic [flash_dump_pkg::BITS - 1 : 0] wr_data, rd_data, tx_char;
logic reader_done, fmt_idle;

assign go = start && !busy;

always_ff @(posedge clk27, posedge rst) begin
	if (rst)
		busy <= 1'b0;
	else if (go)
		busy <= 1'b1;
	else if (reader_done && !rd_valid && fmt_idle && tx_ready)  // drained
		busy <= 1'b0;
end

spi_flash_reader reader (
	.clk27(clk27), .rst(rst), .start(go),
	.flash_clk(flash_clk), .flash_sel(flash_sel),
	.flash_out(flash_out), .flash_in(flash_in),
	.wr_valid(wr_valid), .wr_ready(wr_ready),
	.wr_addr(wr_addr), .wr_data(wr_data),
	.done(reader_done)
);

byte_fifo fifo (
	.clk27(clk27), .rst(rst),
	.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data),
	.rd_valid(rd_valid), .rd_ready(rd_ready), .rd_addr(rd_addr), .rd_data(rd_data)
);

dump_formatter formatter (
	.clk27(clk27), .rst(rst),
	.rd_valid(rd_valid), .rd_ready(rd_ready), .rd_addr(rd_addr), .rd_data(rd_data),
	.tx_valid(tx_valid), .tx_ready(tx_ready), .tx_char(tx_char),
	.idle(fmt_idle)
);

uart_tx uart (
	.clk27(clk27), .rst(rst),
	.tx_valid(tx_valid), .tx_ready(tx_ready), .tx_char(tx_char),
	.serial_tx(serial_tx)
);

endmodule

`default_nettype wire

/* uart_tx.sv */
// asynchronous serial transmitter
// 8N1 at SERIAL_CLK, low bit first, one character per handshake

`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input wire clk27,
	input wire rst,

	input wire tx_valid,
	output logic tx_ready,
	input wire [flash_dump_pkg::BITS - 1 : 0] tx_char,

	output logic serial_tx
);

logic active;
logic [flash_dump_pkg::BITS + 1 : 0] frame;  // stop, data, start
logic [$clog2(flash_dump_pkg::CLKS_PER_BIT) - 1 : 0] baud_cnt;
logic [$clog2(flash_dump_pkg::BITS + 2) - 1 : 0] bit_cnt;

assign tx_ready = !active;
assign serial_tx = frame[0];  // line idles high

always_ff @(posedge clk27, posedge rst) begin
	if (rst) begin
		active <= 1'b0;
		frame <= '1;
		baud_cnt <= '0;
		bit_cnt <= '0;
	end else if (!active) begin
		if (tx_valid) begin
			active <= 1'b1;
			frame <= {1'b1, tx_char, 1'b0};
			baud_cnt <= '0;
			bit_cnt <= '0;
		end
	end else if (baud_cnt == $bits(baud_cnt)'(flash_dump_pkg::CLKS_PER_BIT - 1)) begin
		// bit period over
		baud_cnt <= '0;
		frame <= {1'b1, frame[flash_dump_pkg::BITS + 1 : 1]};
		if (bit_cnt == $bits(bit_cnt)'(flash_dump_pkg::BITS + 1))
			active <= 1'b0;  // stop bit sent
		else
			bit_cnt <= bit_cnt + 1'b1;
	end else begin
		baud_cnt <= baud_cnt + 1'b1;
	end
end

endmodule

`default_nettype wire

/* dump_formatter.sv */
// dump line formatter
// turns one address/data entry into a text line:
// address as three binary groups, raw byte, binary byte, cr/lf.
// characters go out one per handshake

`timescale 1ns/100ps
`default_nettype none

module dump_formatter (
	input wire clk27,
	input wire rst,

	// entries from the fifo
	input wire rd_valid,
	output logic rd_ready,
	input wire [flash_dump_pkg::ADDR_BITS - 1 : 0] rd_addr,
	input wire [flash_dump_pkg::BITS - 1 : 0] rd_data,

	// characters to the uart
	output logic tx_valid,
	input wire tx_ready,
	output logic [flash_dump_pkg::BITS - 1 : 0] tx_char,

	output logic idle
);

logic active;  // a line is being sent
flash_dump_pkg::line_field_t field;
logic [$clog2(flash_dump_pkg::BITS) - 1 : 0] bit_cnt;  // digit within a field

logic [flash_dump_pkg::ADDR_BITS - 1 : 0] addr_q;
logic [flash_dump_pkg::BITS - 1 : 0] data_q;

logic [flash_dump_pkg::BITS - 1 : 0] cur_word;  // word shown as digits
logic digits;  // field has eight binary digits

assign rd_ready = !active;
assign tx_valid = active;
assign idle = !active;


// ----------------------------------------------------------------------------
// character selection
// ----------------------------------------------------------------------------
always_comb begin
	digits = 1'b1;
	cur_word = data_q;
	case (field)
		flash_dump_pkg::ADDR_HI:  cur_word = addr_q[2*flash_dump_pkg::BITS +: flash_dump_pkg::BITS];
		flash_dump_pkg::ADDR_MID: cur_word = addr_q[flash_dump_pkg::BITS +: flash_dump_pkg::BITS];
		flash_dump_pkg::ADDR_LO:  cur_word = addr_q[0 +: flash_dump_pkg::BITS];
		flash_dump_pkg::BIN:      cur_word = data_q;
		default:                  digits = 1'b0;
	endcase
end

always_comb begin
	case (field)
		flash_dump_pkg::SEP1, flash_dump_pkg::SEP2: tx_char = "_";
		flash_dump_pkg::SP1, flash_dump_pkg::SP2:   tx_char = " ";
		flash_dump_pkg::RAW:                        tx_char = data_q;
		flash_dump_pkg::CR:                         tx_char = 8'h0d;
		flash_dump_pkg::LF:                         tx_char = 8'h0a;
		default:  // binary digit, msb first
			tx_char = cur_word[(flash_dump_pkg::BITS - 1) - bit_cnt] ? "1" : "0";
	endcase
end


// ----------------------------------------------------------------------------
// field sequencing
// ----------------------------------------------------------------------------
always_ff @(posedge clk27, posedge rst) begin
	if (rst) begin
		active <= 1'b0;
		field <= flash_dump_pkg::ADDR_HI;
		bit_cnt <= '0;
	end else if (rd_valid && rd_ready) begin
		active <= 1'b1;
		field <= flash_dump_pkg::ADDR_HI;
		bit_cnt <= '0;
	end else if (tx_valid && tx_ready) begin
		if (digits && bit_cnt != $bits(bit_cnt)'(flash_dump_pkg::BITS - 1)) begin
			bit_cnt <= bit_cnt + 1'b1;
		end else begin
			bit_cnt <= '0;
			if (field == flash_dump_pkg::LF)
				active <= 1'b0;  // line complete
			else
				field <= flash_dump_pkg::line_field_t'(field + 1'b1);
		end
	end
end

always_ff @(posedge clk27) begin
	if (rd_valid && rd_ready) begin
		addr_q <= rd_addr;
		data_q <= rd_data;
	end
end

endmodule

`default_nettype wire

/* byte_fifo.sv */
// address/data fifo
// circular buffer between the spi reader and the serial formatter

`timescale 1ns/100ps
`default_nettype none

module byte_fifo (
	input wire clk27,
	input wire rst,

	input wire wr_valid,
	output logic wr_ready,
	input wire [flash_dump_pkg::ADDR_BITS - 1 : 0] wr_addr,
	input wire [flash_dump_pkg::BITS - 1 : 0] wr_data,

	output logic rd_valid,
	input wire rd_ready,
	output logic [flash_dump_pkg::ADDR_BITS - 1 : 0] rd_addr,
	output logic [flash_dump_pkg::BITS - 1 : 0] rd_data
);

logic [flash_dump_pkg::ADDR_BITS - 1 : 0] addr_mem [flash_dump_pkg::FIFO_DEPTH];
logic [flash_dump_pkg::BITS - 1 : 0] data_mem [flash_dump_pkg::FIFO_DEPTH];

logic [$clog2(flash_dump_pkg::FIFO_DEPTH) - 1 : 0] wr_ptr, rd_ptr;
logic [$clog2(flash_dump_pkg::FIFO_DEPTH + 1) - 1 : 0] count;  // occupancy
logic do_wr, do_rd;

assign wr_ready = count != $bits(count)'(flash_dump_pkg::FIFO_DEPTH);  // not full
assign rd_valid = count != '0;  // not empty
assign rd_addr = addr_mem[rd_ptr];
assign rd_data = data_mem[rd_ptr];

assign do_wr = wr_valid && wr_ready;
assign do_rd = rd_valid && rd_ready;

always_ff @(posedge clk27, posedge rst) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_wr)
			wr_ptr <= wr_ptr == $bits(wr_ptr)'(flash_dump_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
		if (do_rd)
			rd_ptr <= rd_ptr == $bits(rd_ptr)'(flash_dump_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
		if (do_wr && !do_rd)
			count <= count + 1'b1;
		else if (do_rd && !do_wr)
			count <= count - 1'b1;
	end
end

always_ff @(posedge clk27) begin
	if (do_wr) begin
		addr_mem[wr_ptr] <= wr_addr;
		data_mem[wr_ptr] <= wr_data;
	end
end

endmodule

`default_nettype wire

/* spi_flash_reader.sv */
// spi flash reader
// sends a READ command from address 0 in spi mode 0 at clk27/2
// and streams the received bytes with their addresses to a fifo.
// a full fifo closes the transaction, which restarts at the next address

`timescale 1ns/100ps
`default_nettype none

module spi_flash_reader (
	input wire clk27,
	input wire rst,
	input wire start,

	// flash pins
	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out,
	input wire flash_in,

	// write side of the fifo
	output logic wr_valid,
	input wire wr_ready,
	output logic [flash_dump_pkg::ADDR_BITS - 1 : 0] wr_addr,
	output logic [flash_dump_pkg::BITS - 1 : 0] wr_data,

	output logic done
);

flash_dump_pkg::reader_state_t state;

logic [flash_dump_pkg::BITS + flash_dump_pkg::ADDR_BITS - 1 : 0] tx_shift;  // opcode & address
logic [flash_dump_pkg::BITS - 1 : 0] rx_shift;
logic [$clog2(flash_dump_pkg::ADDR_BITS) - 1 : 0] bit_cnt;
logic [$clog2(flash_dump_pkg::DUMP_BYTES) - 1 : 0] byte_cnt;
logic [flash_dump_pkg::ADDR_BITS - 1 : 0] cur_addr;  // address of the byte being read
logic byte_end;

assign flash_out = tx_shift[$left(tx_shift)];  // msb first
assign byte_end = state == flash_dump_pkg::DATA && flash_clk
	&& bit_cnt == $bits(bit_cnt)'(flash_dump_pkg::BITS - 1);
assign done = state == flash_dump_pkg::DONE && !wr_valid;  // last byte handed over


// ----------------------------------------------------------------------------
// control
// ----------------------------------------------------------------------------
always_ff @(posedge clk27, posedge rst) begin
	if (rst) begin
		state <= flash_dump_pkg::IDLE;
		flash_clk <= 1'b0;
		flash_sel <= 1'b1;
		tx_shift <= '0;
		bit_cnt <= '0;
		byte_cnt <= '0;
		cur_addr <= '0;
		wr_valid <= 1'b0;
	end else begin
		if (wr_valid && wr_ready)
			wr_valid <= 1'b0;

		case (state)
			flash_dump_pkg::IDLE, flash_dump_pkg::DONE: begin
				if (start) begin
					state <= flash_dump_pkg::CMD;
					flash_sel <= 1'b0;
					tx_shift <= {flash_dump_pkg::OP_READ, flash_dump_pkg::ADDR_BITS'(0)};
					bit_cnt <= '0;
					byte_cnt <= '0;
					cur_addr <= '0;
				end
			end

			flash_dump_pkg::CMD: begin
				flash_clk <= ~flash_clk;
				if (flash_clk) begin  // falling edge, next bit out
					tx_shift <= tx_shift << 1;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == $bits(bit_cnt)'(flash_dump_pkg::BITS - 1)) begin
						state <= flash_dump_pkg::ADDR;
						bit_cnt <= '0;
					end
				end
			end

			flash_dump_pkg::ADDR: begin
				flash_clk <= ~flash_clk;
				if (flash_clk) begin
					tx_shift <= tx_shift << 1;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == $bits(bit_cnt)'(flash_dump_pkg::ADDR_BITS - 1)) begin
						state <= flash_dump_pkg::DATA;
						bit_cnt <= '0;
					end
				end
			end

			flash_dump_pkg::DATA: begin
				flash_clk <= ~flash_clk;
				if (flash_clk)
					bit_cnt <= bit_cnt + 1'b1;
				if (byte_end) begin
					wr_valid <= 1'b1;
					bit_cnt <= '0;
					byte_cnt <= byte_cnt + 1'b1;
					cur_addr <= cur_addr + 1'b1;
					if (byte_cnt == $bits(byte_cnt)'(flash_dump_pkg::DUMP_BYTES - 1)) begin
						state <= flash_dump_pkg::DONE;
						flash_sel <= 1'b1;
					end else if (!wr_ready) begin  // no room for the next byte
						state <= flash_dump_pkg::PAUSE;
						flash_sel <= 1'b1;
					end
				end
			end

			flash_dump_pkg::PAUSE: begin
				// resume once the held byte is taken
				if (!wr_valid || wr_ready) begin
					state <= flash_dump_pkg::CMD;
					flash_sel <= 1'b0;
					tx_shift <= {flash_dump_pkg::OP_READ, cur_addr};
					bit_cnt <= '0;
				end
			end

			default: state <= flash_dump_pkg::IDLE;
		endcase
	end
end


// ----------------------------------------------------------------------------
// data path
// ----------------------------------------------------------------------------
always_ff @(posedge clk27) begin
	if (state == flash_dump_pkg::DATA && !flash_clk)  // rising edge of flash_clk
		rx_shift <= {rx_shift[flash_dump_pkg::BITS - 2 : 0], flash_in};
	if (byte_end) begin
		wr_data <= rx_shift;
		wr_addr <= cur_addr;
	end
end

endmodule

`default_nettype wire

/* flash_dump_pkg.sv */
// flash dump shared definitions
// word and address sizes, dump length, serial timing,
// flash opcodes and the FSM encodings of reader and formatter

`default_nettype none

package flash_dump_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int BITS       = 8;   // one data word
	localparam int ADDR_BITS  = 24;  // three address words
	localparam int DUMP_BYTES = 16;  // bytes read per start
	localparam int FIFO_DEPTH = 4;   // address/data entries
	localparam int LINE_CHARS = 39;  // text line incl. cr/lf

	// ------------------------------------------------------------------------
	// clocks
	// ------------------------------------------------------------------------
	localparam int MAIN_CLK     = 27_000_000;
	localparam int SERIAL_CLK   = 115_200;
	localparam int CLKS_PER_BIT = MAIN_CLK / SERIAL_CLK;  // 234

	// spi flash commands
	typedef enum logic [7:0] {
		OP_READ = 8'h03  // read, 24 bit address follows
	} flash_op_t;

	// reader FSM
	typedef enum logic [2:0] {
		IDLE,
		CMD,    // opcode out
		ADDR,   // address out
		DATA,   // bytes in
		PAUSE,  // fifo full, select released
		DONE
	} reader_state_t;

	// one field per group of characters in a text line
	typedef enum logic [3:0] {
		ADDR_HI, SEP1, ADDR_MID, SEP2, ADDR_LO,
		SP1, RAW, SP2, BIN, CR, LF
	} line_field_t;

endpackage

`default_nettype wire
